/* hw/cnn_ctrl_defs.svh */
`ifndef CNN_CTRL_DEFS_SVH
`define CNN_CTRL_DEFS_SVH

// Region codes in paddr[31:28]
`define CNN_REGION_WEIGHT 4'h8
`define CNN_REGION_BIAS 4'h9

// Status and result word
`define CNN_RESULT_ADDR 32'hffff_ffff

// Layer 1 weights: words stored, then reads in the set sweep
`define CNN_WEIGHT_NUM 216
`define CNN_WEIGHT_SET 72

// Layer 1 biases
`define CNN_BIAS_NUM 8
`define CNN_BIAS_SET 8

// Layer 1 compute time in clock cycles
`define CNN_COMPUTE_CYCLES 3072

// Local memory port widths
`define CNN_MEM_AW 16
`define CNN_MEM_DW 16

`endif

/* hw/cnn_ctrl_pkg.sv */
`include "cnn_ctrl_defs.svh"

package cnn_ctrl_pkg;

	// Region view of an APB address
	typedef struct packed
	{
		logic [3:0] region;
		logic [27:0] offset;
	} apb_addr_fields_t;

	// Raw view for the result address, field view for loader select
	typedef union packed
	{
		logic [31:0] raw;
		apb_addr_fields_t f;
	} apb_addr_u;

	// One accepted write on its way to a loader
	typedef struct packed
	{
		logic strobe;
		logic [`CNN_MEM_DW-1:0] data;
	} load_write_t;

	// Port of one local parameter memory
	typedef struct packed
	{
		logic wr;
		logic rd;
		logic [`CNN_MEM_AW-1:0] addr;
		logic [`CNN_MEM_DW-1:0] data;
	} mem_port_t;

	typedef enum logic [1:0]
	{
		load_idle,
		load_store,
		load_set,
		load_done
	} load_state_e;

endpackage

/* hw/apb_port.sv */
`include "cnn_ctrl_defs.svh"

module apb_port
(
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input cnn_ctrl_pkg::apb_addr_u paddr,
	input logic [31:0] pwdata,
	input logic weight_done,
	input logic bias_done,
	input logic layer_done,
	output logic pready,
	output logic [31:0] prdata,
	output logic pslverr,
	output logic result_read,
	output cnn_ctrl_pkg::load_write_t weight_wr,
	output cnn_ctrl_pkg::load_write_t bias_wr
);

	logic access;
	logic hit_weight;
	logic hit_bias;
	logic hit_result;
	logic weight_stb;
	logic bias_stb;
	logic [`CNN_MEM_DW-1:0] wr_data;
	logic [31:0] status;

	// No wait states
	assign pready = 1'b1;

	assign access = psel & penable;

	// Loader regions come from the field view
	assign hit_weight = (paddr.f.region == `CNN_REGION_WEIGHT);
	assign hit_bias = (paddr.f.region == `CNN_REGION_BIAS);

	// Result word is matched on the whole address
	assign hit_result = (paddr.raw == `CNN_RESULT_ADDR);

	assign pslverr = access & ~(hit_weight | hit_bias | hit_result);

	assign result_read = access & ~pwrite & hit_result;

	always_comb
	begin
		status = '0;
		status[0] = weight_done;
		status[1] = bias_done;
		status[2] = layer_done;
	end

	// Only the result address returns data
	assign prdata = result_read ? status : 32'd0;

	// Strobes last one cycle after the access cycle
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			weight_stb <= 1'b0;
			bias_stb <= 1'b0;
		end
		else
		begin
			weight_stb <= access & pwrite & hit_weight;
			bias_stb <= access & pwrite & hit_bias;
		end
	end

	// Write data for the selected loader
	always_ff @(posedge clk)
	begin
		if (access && pwrite && (hit_weight || hit_bias))
		begin
			wr_data <= pwdata[`CNN_MEM_DW-1:0];
		end
	end

	always_comb
	begin
		weight_wr.strobe = weight_stb;
		weight_wr.data = wr_data;
		bias_wr.strobe = bias_stb;
		bias_wr.data = wr_data;
	end

endmodule

/* hw/param_loader.sv */
`include "cnn_ctrl_defs.svh"

module param_loader
#(
	parameter int NUM = 8,
	parameter int SET = 8
)
(
	input logic clk,
	input logic rst,
	input cnn_ctrl_pkg::load_write_t wr_in,
	output cnn_ctrl_pkg::mem_port_t mem,
	output logic set_done
);

	import cnn_ctrl_pkg::*;

	// Counter values on the cycle of the last store and the last read
	localparam logic [`CNN_MEM_AW-1:0] store_last = `CNN_MEM_AW'(NUM - 1);
	localparam logic [`CNN_MEM_AW-1:0] set_last = `CNN_MEM_AW'(SET - 1);

	load_state_e state;
	logic [`CNN_MEM_AW-1:0] store_cnt;
	logic [`CNN_MEM_AW-1:0] set_cnt;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= load_idle;
			store_cnt <= '0;
			set_cnt <= '0;
		end
		else
		begin
			case (state)
				load_idle, load_store:
				begin
					if (wr_in.strobe)
					begin
						store_cnt <= store_cnt + 1'b1;
						if (store_cnt == store_last)
						begin
							state <= load_set;
						end
						else
						begin
							state <= load_store;
						end
					end
				end
				load_set:
				begin
					set_cnt <= set_cnt + 1'b1;
					if (set_cnt == set_last)
					begin
						state <= load_done;
					end
				end
				load_done:
				begin
					// Later strobes dropped until reset
					state <= load_done;
				end
				default:
				begin
					state <= load_idle;
				end
			endcase
		end
	end

	// Memory port follows the strobe in the same cycle
	always_comb
	begin
		mem = '0;
		case (state)
			load_idle, load_store:
			begin
				if (wr_in.strobe)
				begin
					mem.wr = 1'b1;
					mem.addr = store_cnt;
					mem.data = wr_in.data;
				end
			end
			load_set:
			begin
				mem.rd = 1'b1;
				mem.addr = set_cnt;
			end
			default:
			begin
				mem = '0;
			end
		endcase
	end

	assign set_done = (state == load_done);

endmodule

/* hw/layer_sequencer.sv */
`include "cnn_ctrl_defs.svh"

module layer_sequencer
(
	input logic clk,
	input logic rst,
	input logic weight_done,
	input logic bias_done,
	output logic result_write,
	output logic layer_done
);

	typedef enum logic [1:0]
	{
		seq_idle,
		seq_run,
		seq_finished
	} seq_state_e;

	// Run starts the cycle after both loaders are set, so the pulse lands one earlier
	localparam logic [15:0] cycle_last = 16'(`CNN_COMPUTE_CYCLES - 1);

	seq_state_e state;
	logic [15:0] cycle_cnt;
	logic both_set;

	assign both_set = weight_done & bias_done;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= seq_idle;
			cycle_cnt <= '0;
		end
		else
		begin
			case (state)
				seq_idle:
				begin
					cycle_cnt <= '0;
					if (both_set)
					begin
						state <= seq_run;
					end
				end
				seq_run:
				begin
					cycle_cnt <= cycle_cnt + 1'b1;
					if (cycle_cnt == cycle_last)
					begin
						state <= seq_finished;
					end
				end
				seq_finished:
				begin
					state <= seq_finished;
				end
				default:
				begin
					state <= seq_idle;
				end
			endcase
		end
	end

	assign result_write = (state == seq_run) && (cycle_cnt == cycle_last);

	// Done from the pulse onwards
	assign layer_done = result_write | (state == seq_finished);

endmodule

/* hw/cnn_ctrl_top.sv */
`include "cnn_ctrl_defs.svh"

module cnn_ctrl_top
(
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	output logic pready,
	output logic [31:0] prdata,
	output logic pslverr,
	output logic result_read,
	output logic result_write,
	output cnn_ctrl_pkg::mem_port_t weight_mem,
	output cnn_ctrl_pkg::mem_port_t bias_mem
);

	import cnn_ctrl_pkg::*;

	load_write_t weight_wr;
	load_write_t bias_wr;
	logic weight_done;
	logic bias_done;
	logic layer_done;

	apb_port u_apb_port
	(
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.weight_done(weight_done),
		.bias_done(bias_done),
		.layer_done(layer_done),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr),
		.result_read(result_read),
		.weight_wr(weight_wr),
		.bias_wr(bias_wr)
	);

	param_loader
	#(
		.NUM(`CNN_WEIGHT_NUM),
		.SET(`CNN_WEIGHT_SET)
	)
	u_weight_loader
	(
		.clk(clk),
		.rst(rst),
		.wr_in(weight_wr),
		.mem(weight_mem),
		.set_done(weight_done)
	);

	param_loader
	#(
		.NUM(`CNN_BIAS_NUM),
		.SET(`CNN_BIAS_SET)
	)
	u_bias_loader
	(
		.clk(clk),
		.rst(rst),
		.wr_in(bias_wr),
		.mem(bias_mem),
		.set_done(bias_done)
	);

	layer_sequencer u_layer_sequencer
	(
		.clk(clk),
		.rst(rst),
		.weight_done(weight_done),
		.bias_done(bias_done),
		.result_write(result_write),
		.layer_done(layer_done)
	);

endmodule

/* bench/cnn_ctrl_tb.sv */
`include "cnn_ctrl_defs.svh"

module cnn_ctrl_tb;

	import cnn_ctrl_pkg::*;

	localparam int clk_period = 40;
	// Reads, an unmapped write, the mid status read and a ninth bias word
	localparam int table_len = `CNN_WEIGHT_NUM + `CNN_BIAS_NUM + 5;
	localparam int run_cycles = 3 * table_len + `CNN_WEIGHT_SET + `CNN_BIAS_SET
		+ `CNN_COMPUTE_CYCLES + 10 + 60;
	localparam int margin_cycles = 1000;

	typedef struct packed
	{
		logic [31:0] addr;
		logic [31:0] data;
		logic write;
		logic [31:0] exp_rdata;
		logic exp_err;
	} apb_entry_t;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic pready;
	logic [31:0] prdata;
	logic pslverr;
	logic result_read;
	logic result_write;
	mem_port_t weight_mem;
	mem_port_t bias_mem;

	apb_entry_t stim_q[$];
	integer seed;
	int errors;
	int checks;
	int cyc;
	// Index 0 is the weight memory, index 1 the bias memory
	logic [`CNN_MEM_DW-1:0] exp_data [0:1][0:255];
	int wr_cnt [0:1];
	int rd_cnt [0:1];
	int last_rd [0:1];
	int write_pulses;
	int write_cyc;
	int both_cyc;

	cnn_ctrl_top cnn_ctrl_top_inst
	(
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr),
		.result_read(result_read),
		.result_write(result_write),
		.weight_mem(weight_mem),
		.bias_mem(bias_mem)
	);

	always #(clk_period / 2) clk = ~clk;

	task check_value(input logic [31:0] actual, input logic [31:0] expected, input string what);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	function automatic logic [31:0] status_word(input logic w, input logic b, input logic l);
		return {29'd0, l, b, w};
	endfunction

	task add_entry(input logic [31:0] addr, input logic [31:0] data, input logic write,
		input logic [31:0] exp_rdata, input logic exp_err);
		stim_q.push_back({addr, data, write, exp_rdata, exp_err});
	endtask

	task build_table;
		logic [31:0] word;
		int i;
		add_entry(`CNN_RESULT_ADDR, 32'd0, 1'b0, status_word(0, 0, 0), 1'b0);
		add_entry(32'h3000_0000, 32'd0, 1'b0, 32'd0, 1'b1);
		for (i = 0; i < `CNN_WEIGHT_NUM; i++)
		begin
			word = $random(seed);
			exp_data[0][i] = word[15:0];
			add_entry({`CNN_REGION_WEIGHT, 28'(i * 4)}, word, 1'b1, 32'd0, 1'b0);
			if (i < `CNN_BIAS_NUM)
			begin
				word = $random(seed);
				exp_data[1][i] = word[15:0];
				add_entry({`CNN_REGION_BIAS, 28'(i * 4)}, word, 1'b1, 32'd0, 1'b0);
			end
			if (i == 3)
			begin
				add_entry(32'h3000_0010, 32'h1234_5678, 1'b1, 32'd0, 1'b1);
			end
			// Biases are set by now, weights are still loading
			if (i == 20)
			begin
				add_entry(`CNN_RESULT_ADDR, 32'd0, 1'b0, status_word(0, 1, 0), 1'b0);
			end
			if (i == 30)
			begin
				add_entry({`CNN_REGION_BIAS, 28'h20}, 32'h0bad_0bad, 1'b1, 32'd0, 1'b0);
			end
		end
	endtask

	task apb_write(input logic [31:0] addr, input logic [31:0] data, input logic exp_err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		#(clk_period / 4);
		check_value(pready, 1'b1, "pready on write");
		check_value(pslverr, exp_err, $sformatf("pslverr on write to %h", addr));
		check_value(result_read, 1'b0, "result_read on write");
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task apb_read(input logic [31:0] addr, input logic [31:0] exp_rdata, input logic exp_err);
		logic is_result;
		is_result = (addr == `CNN_RESULT_ADDR);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		#(clk_period / 4);
		check_value(pready, 1'b1, "pready on read");
		check_value(pslverr, exp_err, $sformatf("pslverr on read of %h", addr));
		check_value(result_read, is_result, $sformatf("result_read on read of %h", addr));
		if (is_result)
		begin
			check_value(prdata, exp_rdata, "status word");
		end
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task apply_entry(input apb_entry_t e);
		if (e.write)
		begin
			apb_write(e.addr, e.data, e.exp_err);
		end
		else
		begin
			apb_read(e.addr, e.exp_rdata, e.exp_err);
		end
	endtask

	task track_mem_port(input int idx, input mem_port_t port);
		int num;
		int sweep_len;
		string name;
		num = (idx == 0) ? `CNN_WEIGHT_NUM : `CNN_BIAS_NUM;
		sweep_len = (idx == 0) ? `CNN_WEIGHT_SET : `CNN_BIAS_SET;
		name = (idx == 0) ? "weight" : "bias";
		if (port.wr)
		begin
			check_value(32'(wr_cnt[idx] < num), 1, {name, " write within word count"});
			if (wr_cnt[idx] < num)
			begin
				check_value(port.addr, wr_cnt[idx], {name, " write address"});
				check_value(port.data, exp_data[idx][wr_cnt[idx]], {name, " write data"});
			end
			wr_cnt[idx]++;
		end
		if (port.rd)
		begin
			check_value(32'(wr_cnt[idx] == num), 1, {name, " read after all words stored"});
			check_value(32'(rd_cnt[idx] < sweep_len), 1, {name, " read within sweep"});
			if (rd_cnt[idx] > 0)
			begin
				check_value(cyc, last_rd[idx] + 1, {name, " reads on consecutive cycles"});
			end
			check_value(port.addr, rd_cnt[idx], {name, " read address"});
			rd_cnt[idx]++;
			last_rd[idx] = cyc;
		end
	endtask

	// Memory ports and result_write are stable around the falling edge
	always @(negedge clk)
	begin
		cyc = cyc + 1;
		track_mem_port(0, weight_mem);
		track_mem_port(1, bias_mem);
		if (result_write)
		begin
			write_pulses++;
			write_cyc = cyc;
		end
	end

	initial
	begin
		#((run_cycles + margin_cycles) * clk_period);
		$display("timeout, the run did not finish within %0d clock cycles",
			run_cycles + margin_cycles);
		$display("test failed");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 32'd0;
		pwdata = 32'd0;
		seed = 32'hfab2_2f5a;
		errors = 0;
		checks = 0;
		cyc = 0;
		write_pulses = 0;
		write_cyc = 0;
		for (int i = 0; i < 2; i++)
		begin
			wr_cnt[i] = 0;
			rd_cnt[i] = 0;
			last_rd[i] = 0;
		end
		build_table();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		foreach (stim_q[i])
		begin
			apply_entry(stim_q[i]);
		end

		// Both sweeps over, set_done follows on the next cycle
		wait (rd_cnt[0] == `CNN_WEIGHT_SET && rd_cnt[1] == `CNN_BIAS_SET);
		apb_read(`CNN_RESULT_ADDR, status_word(1, 1, 0), 1'b0);
		both_cyc = ((last_rd[0] > last_rd[1]) ? last_rd[0] : last_rd[1]) + 1;

		wait (write_pulses > 0);
		check_value(write_cyc, both_cyc + `CNN_COMPUTE_CYCLES, "result_write cycle");
		apb_read(`CNN_RESULT_ADDR, status_word(1, 1, 1), 1'b0);
		repeat (50) @(negedge clk);

		check_value(write_pulses, 1, "result_write pulse count");
		check_value(wr_cnt[0], `CNN_WEIGHT_NUM, "weight words stored");
		check_value(wr_cnt[1], `CNN_BIAS_NUM, "bias words stored");
		check_value(rd_cnt[0], `CNN_WEIGHT_SET, "weight sweep reads");
		check_value(rd_cnt[1], `CNN_BIAS_SET, "bias sweep reads");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("test passed");
		end
		else
		begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+hw
hw/cnn_ctrl_pkg.sv
hw/apb_port.sv
hw/param_loader.sv
hw/layer_sequencer.sv
hw/cnn_ctrl_top.sv
bench/cnn_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and scan the log for the verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cnn_ctrl_tb -f project.f \
	-o cnn_ctrl_sim > build.log 2>&1 ||
	{ echo "build failed, see build.log"; exit 1; }

./obj_dir/cnn_ctrl_sim > sim.log 2>&1 &&
	! grep -q "test failed" sim.log &&
	{ echo "PASS"; exit 0; } ||
	{ echo "FAIL, see sim.log"; exit 1; }
